// File: arbCtrlPkg.sv
// types for the arbiter control path
package arbCtrlPkg;

    // arbiter sequencer states
    typedef enum logic [1:0] {
        stIdle,          // looking at requests
        stAddr,          // command out, waiting on txDone
        stReadWait,      // waiting for read data
        stWriteAck       // one cycle write ack
    } arbState_t;

    // who owns the bus right now
    typedef enum logic [1:0] {
        clNone,          // no grant
        clCache,         // cache front end
        clSig            // signal stream front end
    } client_t;

endpackage

// File: cacheReqPort.sv
`timescale 1ns/1ps
`include "memArb_macros.svh"

// instruction and data cache front end
// data cache beats instruction cache, eviction beats data miss
module cacheReqPort
    import memBusPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  instrReq,      // icache miss
    input  addr_t instrAddr,
    input  logic  dataReq,       // dcache miss
    input  logic  dataEvict,     // dirty block leaving dcache
    input  addr_t dataAddr,
    input  blk_t  dataWrBlk,     // evicted block
    output blk_t  instrBlk,
    output logic  instrValid,
    output blk_t  dataBlk,
    output logic  dataValid,
    output logic  evictAck,
    memReqIf.client memReq
);

    logic  dataAny;      // dcache wants the bus for anything
    logic  selData;      // dcache is the current pick
    logic  busy;         // transaction in flight
    logic  ownData;      // in-flight transaction belongs to dcache
    logic  done;         // response pulse from arbiter
    addr_t rawAddr;      // address before alignment

    assign dataAny = dataReq | dataEvict;
    assign done    = memReq.rdValid | memReq.wrDone;

    // fresh pick when idle, frozen owner while busy
    assign selData = busy ? ownData : dataAny;

    // request toward the arbiter, straight from the cache ports
    assign memReq.req    = selData ? dataAny : instrReq;
    assign memReq.write  = selData & dataEvict;    // eviction goes out as a write
    assign rawAddr       = selData ? dataAddr : instrAddr;
    assign memReq.addr   = rawAddr & `ALIGN_MASK;
    assign memReq.wrData = dataWrBlk;              // only looked at on writes

    // owner register
    // a data request showing up mid read of icache must not grab its block
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            ownData <= 1'b0;
        end else if (done) begin
            busy <= 1'b0;                          // next pick one cycle after the pulse
        end else if (!busy && memReq.req) begin
            busy    <= 1'b1;
            ownData <= dataAny;                    // same pick the arbiter saw
        end
    end

    // block goes to both caches, the pulse says who takes it
    assign instrBlk = memReq.rdData;
    assign dataBlk  = memReq.rdData;

    // steer pulses by owner
    assign instrValid = memReq.rdValid & busy & ~ownData;
    assign dataValid  = memReq.rdValid & busy & ownData;
    assign evictAck   = memReq.wrDone & busy & ownData;    // only dcache writes

endmodule

// File: memArbTb.sv
`timescale 1ns/1ps
`include "memArb_macros.svh"

// testbench for memArbTop with a behavioral host memory controller
module memArbTb
    import memBusPkg::*;
();

    typedef enum {
        tkInstr, tkDataRd, tkEvict, tkPrioInstr, tkPrioAccel, tkChunkRd, tkChunkWr
    } testKind_t;

    typedef struct {
        string     name;
        testKind_t kind;
        addr_t     addr;       // cache address, or sigNum for stream tests
        addr_t     addr2;      // second cache address in priority tests
        blk_t      wrData;
        addr_t     expAddr;    // first bus address expected
        addr_t     expAddr2;
    } testEntry_t;

    // bit positions in pulses
    localparam int pInstr = 0;
    localparam int pData  = 1;
    localparam int pEvict = 2;
    localparam int pRd    = 3;
    localparam int pWr    = 4;
    localparam int pDone  = 5;

    logic clk = 1'b0;
    logic rst;
    logic instrReq, dataReq, dataEvict, accelRd, accelWr, sigTblWe;
    addr_t instrAddr, dataAddr;
    blk_t dataWrBlk, accelWrBlk, busIn;
    logic [`SIG_IDX_WIDTH-1:0] sigNum, sigTblIdx;
    logic [`SIG_BASE_WIDTH-1:0] sigTblBase;
    logic txDone, rdValid;
    blk_t instrBlk, dataBlk, accelRdBlk, busOut;
    logic instrValid, dataValid, evictAck, accelRdDone, accelWrDone, transformComplete;
    memOp_t op;
    addr_t ioAddr;

    logic [5:0] pulses;
    int pulseCnt [6];
    logic [`SIG_BASE_WIDTH-1:0] tblBase [`SIG_TBL_DEPTH];   // tb copy of the signal table
    testEntry_t tests [$];
    addr_t cmdAddrQ [$];   // every command address, in bus order
    addr_t wrAddrQ [$];
    blk_t  wrDataQ [$];
    int cycleCnt = 0;
    int cycleLimit = 0;
    int txCount = 0;

    memArbTop i_dut (.*);

    always #5 clk = ~clk;

    assign pulses = {transformComplete, accelWrDone, accelRdDone, evictAck, dataValid, instrValid};

    // memory content is the address replicated over the block
    function automatic blk_t blockFor(input addr_t a);
        return {(`BLK_WIDTH / `ADDR_WIDTH){a}};
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkVal(input string name, input blk_t exp, input blk_t act);
        assert (act === exp) else begin
            failRun($sformatf("Fail %s expected %0h actual %0h", name, exp, act));
        end
    endtask

    // controller model with latencies of 1 to 4 cycles
    always begin : memModel
        int    lat;
        addr_t a;
        logic  isRd;
        @(negedge clk);
        if (!rst && op != opIdle) begin
            lat = $urandom_range(1, 4);
            repeat (lat - 1) @(negedge clk);
            a    = ioAddr;            // held by the arbiter until txDone
            isRd = (op == opRead);
            cmdAddrQ.push_back(a);
            if (!isRd) begin
                wrAddrQ.push_back(a);
                wrDataQ.push_back(busOut);
            end
            txDone = 1'b1;
            @(negedge clk);
            txDone = 1'b0;
            if (isRd) begin
                lat = $urandom_range(1, 4);
                repeat (lat - 1) @(negedge clk);
                busIn   = blockFor(a);
                rdValid = 1'b1;
                @(negedge clk);
                rdValid = 1'b0;
            end
        end
    end

    // pulse counters sampled once per cycle after the falling edge
    always begin
        @(negedge clk);
        #1;
        for (int i = 0; i < 6; i++) begin
            if (pulses[i]) pulseCnt[i]++;
        end
    end

    // the bound checker counts its assertion failures
    always @(negedge clk) begin
        assert (i_dut.uArb.uProps.failCnt == 0) else begin
            failRun("a protocol assertion in the arbiter failed");
        end
    end

    always @(posedge clk) begin
        cycleCnt++;
        if (cycleCnt > cycleLimit) begin
            failRun($sformatf("Timeout: the run did not finish within %0d cycles", cycleLimit));
        end
    end

    task automatic addTest(input string name, input testKind_t kind, input addr_t a,
                           input addr_t a2, input blk_t wd);
        testEntry_t t;
        t.name   = name;
        t.kind   = kind;
        t.addr   = a;
        t.addr2  = a2;
        t.wrData = wd;
        if (kind inside {tkChunkRd, tkChunkWr, tkPrioAccel}) begin
            // region base plus the table base as a block stride at offset 0
            t.expAddr = 32'h1000_0000 + (addr_t'(tblBase[a[3:0]]) << 11);
        end else begin
            t.expAddr = a & 32'hFFFF_FFF0;
        end
        t.expAddr2 = a2 & 32'hFFFF_FFF0;
        tests.push_back(t);
    endtask

    task automatic loadTable();
        for (int i = 0; i < `SIG_TBL_DEPTH; i++) begin
            @(negedge clk);
            sigTblWe   = 1'b1;
            sigTblIdx  = i[`SIG_IDX_WIDTH-1:0];
            sigTblBase = tblBase[i];
        end
        @(negedge clk);
        sigTblWe = 1'b0;
    endtask

    task automatic waitPulse(input int which);
        do begin
            @(negedge clk);
            #1;                       // past the falling edge drives
        end while (!pulses[which]);
    endtask

    task automatic runTest(input testEntry_t t);
        int    expCnt [6];
        addr_t a;
        blk_t  d;
        expCnt   = '{default: 0};
        pulseCnt = '{default: 0};
        cmdAddrQ.delete();
        wrAddrQ.delete();
        wrDataQ.delete();
        @(negedge clk);
        case (t.kind)
            tkInstr: begin
                instrReq  = 1'b1;
                instrAddr = t.addr;
                waitPulse(pInstr);
                checkVal(t.name, t.expAddr, cmdAddrQ[0]);
                checkVal(t.name, blockFor(t.expAddr), instrBlk);
                expCnt[pInstr] = 1;
            end
            tkDataRd: begin
                dataReq  = 1'b1;
                dataAddr = t.addr;
                waitPulse(pData);
                checkVal(t.name, t.expAddr, cmdAddrQ[0]);
                checkVal(t.name, blockFor(t.expAddr), dataBlk);
                expCnt[pData] = 1;
            end
            tkEvict: begin
                dataEvict = 1'b1;
                dataAddr  = t.addr;
                dataWrBlk = t.wrData;
                waitPulse(pEvict);
                checkVal(t.name, t.expAddr, wrAddrQ[0]);
                checkVal(t.name, t.wrData, wrDataQ[0]);
                expCnt[pEvict] = 1;
            end
            tkPrioInstr: begin
                dataReq   = 1'b1;             // both caches in the same cycle
                dataAddr  = t.addr;
                instrReq  = 1'b1;
                instrAddr = t.addr2;
                waitPulse(pData);
                checkVal(t.name, t.expAddr, cmdAddrQ[0]);
                checkVal(t.name, blockFor(t.expAddr), dataBlk);
                @(negedge clk);
                dataReq = 1'b0;
                waitPulse(pInstr);
                checkVal(t.name, t.expAddr2, cmdAddrQ[1]);
                checkVal(t.name, blockFor(t.expAddr2), instrBlk);
                expCnt[pInstr] = 1;
                expCnt[pData]  = 1;
            end
            tkPrioAccel: begin
                accelRd  = 1'b1;
                sigNum   = t.addr[`SIG_IDX_WIDTH-1:0];
                dataReq  = 1'b1;
                dataAddr = t.addr2;
                waitPulse(pRd);
                checkVal(t.name, t.expAddr, cmdAddrQ[0]);
                checkVal(t.name, blockFor(t.expAddr), accelRdBlk);
                @(negedge clk);
                accelRd = 1'b0;
                waitPulse(pData);
                checkVal(t.name, t.expAddr2, cmdAddrQ[1]);
                checkVal(t.name, blockFor(t.expAddr2), dataBlk);
                expCnt[pRd]   = 1;
                expCnt[pData] = 1;
            end
            tkChunkRd: begin
                sigNum = t.addr[`SIG_IDX_WIDTH-1:0];
                for (int k = 0; k < `SIG_CHUNK_BLKS; k++) begin
                    a = t.expAddr + (k << 11);    // next block of the chunk
                    accelRd = 1'b1;
                    waitPulse(pRd);
                    checkVal(t.name, a, cmdAddrQ[k]);
                    checkVal(t.name, blockFor(a), accelRdBlk);
                    @(negedge clk);
                    accelRd = 1'b0;
                    @(negedge clk);
                end
                expCnt[pRd] = `SIG_CHUNK_BLKS;
            end
            tkChunkWr: begin
                sigNum = t.addr[`SIG_IDX_WIDTH-1:0];
                for (int k = 0; k < `SIG_CHUNK_BLKS; k++) begin
                    a = t.expAddr + (k << 11);
                    d = t.wrData + k;
                    accelWrBlk = d;
                    accelWr    = 1'b1;
                    waitPulse(pWr);
                    checkVal(t.name, a, wrAddrQ[k]);
                    checkVal(t.name, d, wrDataQ[k]);
                    checkVal(t.name, k == `SIG_CHUNK_BLKS - 1, transformComplete);
                    @(negedge clk);
                    accelWr = 1'b0;
                    @(negedge clk);
                end
                expCnt[pWr]   = `SIG_CHUNK_BLKS;
                expCnt[pDone] = 1;       // only with the last block
            end
            default: failRun($sformatf("unknown test kind in entry %s", t.name));
        endcase
        @(negedge clk);
        instrReq  = 1'b0;
        dataReq   = 1'b0;
        dataEvict = 1'b0;
        repeat (3) @(negedge clk);       // let stray pulses show up
        for (int i = 0; i < 6; i++) begin
            checkVal({t.name, " pulse count"}, expCnt[i], pulseCnt[i]);
        end
    endtask

    initial begin
        void'($urandom(96126));
        rst        = 1'b1;
        instrReq   = 1'b0;
        instrAddr  = '0;
        dataReq    = 1'b0;
        dataEvict  = 1'b0;
        dataAddr   = '0;
        dataWrBlk  = '0;
        accelRd    = 1'b0;
        accelWr    = 1'b0;
        accelWrBlk = '0;
        sigNum     = '0;
        sigTblWe   = 1'b0;
        sigTblIdx  = '0;
        sigTblBase = '0;
        txDone     = 1'b0;
        rdValid    = 1'b0;
        busIn      = '0;
        for (int i = 0; i < `SIG_TBL_DEPTH; i++) begin
            tblBase[i] = 21'h00400 + i * 21'h00123;
        end
        addTest("instrMiss", tkInstr, 32'h0000_1234, '0, '0);
        addTest("dataMiss", tkDataRd, 32'h0002_0A5C, '0, '0);
        addTest("evict", tkEvict, 32'h0003_3FF7, '0, {(`BLK_WIDTH / 32){$urandom}});
        addTest("prioInstrData", tkPrioInstr, 32'h0004_0008, 32'h0005_0104, '0);
        addTest("chunkRead", tkChunkRd, 3, '0, '0);
        addTest("chunkWrite", tkChunkWr, 3, '0, {(`BLK_WIDTH / 32){$urandom}});
        addTest("prioAccelData", tkPrioAccel, 5, 32'h0006_00F1, '0);   // read offset back at 0
        foreach (tests[i]) begin
            case (tests[i].kind)
                tkChunkRd, tkChunkWr: txCount += `SIG_CHUNK_BLKS;
                tkPrioInstr, tkPrioAccel: txCount += 2;
                default: txCount += 1;
            endcase
        end
        cycleLimit = txCount * 12 + 200;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        loadTable();
        foreach (tests[i]) begin
            runTest(tests[i]);
        end
        if (i_dut.uArb.uProps.failCnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            failRun("a protocol assertion in the arbiter failed");
        end
    end

endmodule

// File: memArbTop.sv
`timescale 1ns/1ps
`include "memArb_macros.svh"

// memory arbiter top
// cache and signal stream front ends share one host memory controller
module memArbTop
    import memBusPkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    // instruction cache
    input  logic                       instrReq,
    input  addr_t                      instrAddr,
    output blk_t                       instrBlk,
    output logic                       instrValid,
    // data cache
    input  logic                       dataReq,
    input  logic                       dataEvict,
    input  addr_t                      dataAddr,
    input  blk_t                       dataWrBlk,
    output blk_t                       dataBlk,
    output logic                       dataValid,
    output logic                       evictAck,
    // accelerator buffer
    input  logic                       accelRd,
    input  logic                       accelWr,
    input  blk_t                       accelWrBlk,
    input  logic [`SIG_IDX_WIDTH-1:0]  sigNum,
    output blk_t                       accelRdBlk,
    output logic                       accelRdDone,
    output logic                       accelWrDone,
    output logic                       transformComplete,
    // signal table load
    input  logic                       sigTblWe,
    input  logic [`SIG_IDX_WIDTH-1:0]  sigTblIdx,
    input  logic [`SIG_BASE_WIDTH-1:0] sigTblBase,
    // host memory controller
    output memOp_t                     op,
    output addr_t                      ioAddr,
    output blk_t                       busOut,
    input  logic                       txDone,
    input  logic                       rdValid,
    input  blk_t                       busIn
);

    memReqIf cacheReq ();     // cache front end to arbiter
    memReqIf sigReq ();       // stream front end to arbiter

    cacheReqPort uCachePort (
        .clk        (clk),
        .rst        (rst),
        .instrReq   (instrReq),
        .instrAddr  (instrAddr),
        .dataReq    (dataReq),
        .dataEvict  (dataEvict),
        .dataAddr   (dataAddr),
        .dataWrBlk  (dataWrBlk),
        .instrBlk   (instrBlk),
        .instrValid (instrValid),
        .dataBlk    (dataBlk),
        .dataValid  (dataValid),
        .evictAck   (evictAck),
        .memReq     (cacheReq.client)
    );

    sigStreamPort uSigPort (
        .clk               (clk),
        .rst               (rst),
        .accelRd           (accelRd),
        .accelWr           (accelWr),
        .accelWrBlk        (accelWrBlk),
        .sigNum            (sigNum),
        .sigTblWe          (sigTblWe),
        .sigTblIdx         (sigTblIdx),
        .sigTblBase        (sigTblBase),
        .accelRdBlk        (accelRdBlk),
        .accelRdDone       (accelRdDone),
        .accelWrDone       (accelWrDone),
        .transformComplete (transformComplete),
        .memReq            (sigReq.client)
    );

    memBusArbiter uArb (
        .clk      (clk),
        .rst      (rst),
        .txDone   (txDone),
        .rdValid  (rdValid),
        .busIn    (busIn),
        .op       (op),
        .ioAddr   (ioAddr),
        .busOut   (busOut),
        .cacheReq (cacheReq.arbiter),
        .sigReq   (sigReq.arbiter)
    );

endmodule

// File: memArb_macros.svh
`ifndef MEMARB_MACROS_SVH
`define MEMARB_MACROS_SVH

// host memory controller bus widths
`define BLK_WIDTH 512                // one cache block per transfer
`define ADDR_WIDTH 32                // byte address

// cache addresses go out on 16 byte boundaries
`define ALIGN_MASK 32'hFFFF_FFF0

// signal table geometry
`define SIG_TBL_DEPTH 16             // entries, one per signal
`define SIG_IDX_WIDTH 4              // log2 of table depth

// base block number width
// what is left of the address above the block stride
`define SIG_BASE_WIDTH 21

// chunk layout in host memory
`define SIG_CHUNK_BLKS 8             // blocks per chunk, read and write alike
`define SIG_BLK_SHIFT 11             // block number to byte stride

// all signal chunks live above this byte address
`define SIG_REGION_BASE 32'h1000_0000

`endif

// File: memArb_props.sv
`timescale 1ns/1ps

// protocol checks bound into memBusArbiter
module memArbProps
    import memBusPkg::*;
    import arbCtrlPkg::*;
(
    input logic      clk,
    input logic      rst,
    input arbState_t state,
    input memOp_t    op,
    input addr_t     ioAddr,
    input logic      txDone,
    input logic      cacheRdValid,
    input logic      cacheWrDone,
    input logic      sigRdValid,
    input logic      sigWrDone
);

    logic cachePulse;     // any done toward the cache side
    logic sigPulse;
    int   failCnt = 0;    // failed assertions so far

    assign cachePulse = cacheRdValid | cacheWrDone;
    assign sigPulse   = sigRdValid | sigWrDone;

    // bus quiet while idle
    idleQuiet: assert property (@(posedge clk) disable iff (rst)
        state == stIdle |-> op == opIdle)
        else begin
            failCnt++;
            $error("op driven while the arbiter is idle");
        end

    // one owner per pulse
    onePulse: assert property (@(posedge clk) disable iff (rst)
        !(cachePulse && sigPulse))
        else begin
            failCnt++;
            $error("done pulse on both request channels in one cycle");
        end

    // address held under back pressure until txDone
    addrHold: assert property (@(posedge clk) disable iff (rst)
        (state == stAddr && !txDone) |=> $stable(ioAddr))
        else begin
            failCnt++;
            $error("ioAddr changed before txDone");
        end

endmodule

bind memBusArbiter memArbProps uProps (
    .clk          (clk),
    .rst          (rst),
    .state        (state),
    .op           (op),
    .ioAddr       (ioAddr),
    .txDone       (txDone),
    .cacheRdValid (cacheReq.rdValid),
    .cacheWrDone  (cacheReq.wrDone),
    .sigRdValid   (sigReq.rdValid),
    .sigWrDone    (sigReq.wrDone)
);

// File: memBusArbiter.sv
`timescale 1ns/1ps

// fixed priority arbiter plus memory controller sequencer
// signal stream first, then cache
module memBusArbiter
    import memBusPkg::*;
    import arbCtrlPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   txDone,        // controller took the command
    input  logic   rdValid,       // read data on busIn
    input  blk_t   busIn,
    output memOp_t op,
    output addr_t  ioAddr,
    output blk_t   busOut,
    memReqIf.arbiter cacheReq,
    memReqIf.arbiter sigReq
);

    arbState_t state;
    arbState_t nextState;
    client_t   grant;             // owner of the current transaction
    client_t   nextGrant;

    logic  gWrite;                // granted command
    addr_t gAddr;
    blk_t  gData;
    logic  inAddr;
    logic  readBack;              // read data arriving now
    logic  writeBack;             // write ack cycle

    // pick the granted client's request lines
    // clients hold these until their done pulse
    always_comb begin
        if (grant == clSig) begin
            gWrite = sigReq.write;
            gAddr  = sigReq.addr;
            gData  = sigReq.wrData;
        end else begin
            gWrite = cacheReq.write;
            gAddr  = cacheReq.addr;
            gData  = cacheReq.wrData;
        end
    end

    // sequencer next state
    always_comb begin
        nextState = state;
        nextGrant = grant;
        case (state)
            stIdle: begin
                if (sigReq.req) begin              // accelerator wins
                    nextGrant = clSig;
                    nextState = stAddr;
                end else if (cacheReq.req) begin
                    nextGrant = clCache;
                    nextState = stAddr;
                end
            end
            stAddr: begin
                if (txDone) begin                  // back pressure ends here
                    nextState = gWrite ? stWriteAck : stReadWait;
                end
            end
            stReadWait: begin
                if (rdValid) begin
                    nextState = stIdle;
                    nextGrant = clNone;
                end
            end
            stWriteAck: begin
                nextState = stIdle;                // single ack cycle
                nextGrant = clNone;
            end
            default: begin
                nextState = stIdle;
                nextGrant = clNone;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= stIdle;
            grant <= clNone;
        end else begin
            state <= nextState;
            grant <= nextGrant;
        end
    end

    // command held on the bus until txDone
    assign inAddr = (state == stAddr);
    assign op     = inAddr ? (gWrite ? opWrite : opRead) : opIdle;
    assign ioAddr = inAddr ? gAddr : '0;
    assign busOut = inAddr ? gData : '0;

    assign readBack  = (state == stReadWait) & rdValid;
    assign writeBack = (state == stWriteAck);

    // data to both, pulses only to the owner
    assign cacheReq.rdData  = busIn;
    assign sigReq.rdData    = busIn;
    assign cacheReq.rdValid = readBack & (grant == clCache);
    assign sigReq.rdValid   = readBack & (grant == clSig);
    assign cacheReq.wrDone  = writeBack & (grant == clCache);
    assign sigReq.wrDone    = writeBack & (grant == clSig);

endmodule

// File: memBusPkg.sv
`include "memArb_macros.svh"

// types seen on the host memory controller side
package memBusPkg;

    // controller opcodes
    // encoding matches the controller, write is 2'b11
    typedef enum logic [1:0] {
        opIdle  = 2'b00,     // nothing on the bus
        opRead  = 2'b01,     // block read
        opWrite = 2'b11      // block write
    } memOp_t;

    // one full block of data
    typedef logic [`BLK_WIDTH-1:0] blk_t;

    // byte address toward host memory
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

endpackage

// File: memReqIf.sv
`timescale 1ns/1ps

// one front end's request channel into the bus arbiter
interface memReqIf import memBusPkg::*; ();

    // request side, held until the matching done pulse
    logic  req;          // level request
    logic  write;        // 1 write, 0 read
    addr_t addr;         // aligned byte address
    blk_t  wrData;       // write payload

    // response side
    blk_t  rdData;       // read payload, valid with rdValid
    logic  rdValid;      // single cycle read done
    logic  wrDone;       // single cycle write done

    modport client (
        output req, write, addr, wrData,
        input  rdData, rdValid, wrDone
    );

    modport arbiter (
        input  req, write, addr, wrData,
        output rdData, rdValid, wrDone
    );

endinterface

// File: sigStreamPort.sv
`timescale 1ns/1ps
`include "memArb_macros.svh"

// accelerator buffer front end
// streams one chunk in from host memory and one chunk back out
module sigStreamPort
    import memBusPkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       accelRd,      // want next block of the chunk
    input  logic                       accelWr,      // next block ready to go out
    input  blk_t                       accelWrBlk,
    input  logic [`SIG_IDX_WIDTH-1:0]  sigNum,       // which signal
    input  logic                       sigTblWe,     // table load strobe
    input  logic [`SIG_IDX_WIDTH-1:0]  sigTblIdx,
    input  logic [`SIG_BASE_WIDTH-1:0] sigTblBase,   // base block number
    output blk_t                       accelRdBlk,
    output logic                       accelRdDone,
    output logic                       accelWrDone,
    output logic                       transformComplete,
    memReqIf.client memReq
);

    localparam int offWidth = $clog2(`SIG_CHUNK_BLKS);
    localparam logic [offWidth-1:0] lastOff = offWidth'(`SIG_CHUNK_BLKS - 1);

    logic [`SIG_BASE_WIDTH-1:0] sigTbl [`SIG_TBL_DEPTH];   // base block per signal

    logic [offWidth-1:0] rdOff;      // block index within the read chunk
    logic [offWidth-1:0] wrOff;      // block index within the write chunk
    logic [offWidth-1:0] curOff;
    logic  busy;                     // transaction in flight
    logic  dirWr;                    // direction of the in-flight transaction
    logic  wantWr;
    logic  curWr;
    addr_t baseByte;                 // table base as a byte offset
    addr_t offByte;                  // chunk offset as a byte offset

    // table load port, host fills it before streaming
    always_ff @(posedge clk) begin
        if (sigTblWe) begin
            sigTbl[sigTblIdx] <= sigTblBase;
        end
    end

    // read first if both are up
    assign wantWr = accelWr & ~accelRd;
    assign curWr  = busy ? dirWr : wantWr;    // hold direction until done
    assign curOff = curWr ? wrOff : rdOff;

    // region base + (base << 11) + (off << 11)
    assign baseByte = {sigTbl[sigNum], {`SIG_BLK_SHIFT{1'b0}}};
    assign offByte  = addr_t'(curOff) << `SIG_BLK_SHIFT;

    assign memReq.req    = accelRd | accelWr;
    assign memReq.write  = curWr;
    assign memReq.addr   = `SIG_REGION_BASE + baseByte + offByte;
    assign memReq.wrData = accelWrBlk;

    // direction latch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            dirWr <= 1'b0;
        end else if (memReq.rdValid || memReq.wrDone) begin
            busy <= 1'b0;
        end else if (!busy && memReq.req) begin
            busy  <= 1'b1;
            dirWr <= wantWr;
        end
    end

    // chunk offsets, wrap after a full chunk
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdOff <= '0;
            wrOff <= '0;
        end else begin
            if (memReq.rdValid) begin
                rdOff <= (rdOff == lastOff) ? '0 : rdOff + 1'b1;
            end
            if (memReq.wrDone) begin
                wrOff <= (wrOff == lastOff) ? '0 : wrOff + 1'b1;
            end
        end
    end

    assign accelRdBlk  = memReq.rdData;
    assign accelRdDone = memReq.rdValid;      // arbiter only pulses the granted side
    assign accelWrDone = memReq.wrDone;

    // last block of the write chunk is out
    assign transformComplete = memReq.wrDone & (wrOff == lastOff);

endmodule

// File: vlog.f
+incdir+.
memBusPkg.sv
arbCtrlPkg.sv
memReqIf.sv
cacheReqPort.sv
sigStreamPort.sv
memBusArbiter.sv
memArbTop.sv
memArb_props.sv
memArbTb.sv
